// ==== msxCartPkg.sv ====
package msxCartPkg;

    // Basic bus types
    typedef logic [7:0]  byteT;
    typedef logic [15:0] busAddrT;

    // External RAM
    localparam int RamAddrWidth = 17;
    typedef logic [RamAddrWidth-1:0] ramAddrT;

    // Boot flash
    localparam int FlashAddrWidth = 20;
    typedef logic [FlashAddrWidth-1:0] flashAddrT;

    // BIOS image, copied from flash into RAM at boot
    localparam flashAddrT BiosFlashBase  = 20'h10000;
    localparam ramAddrT   BiosRamBase    = 17'h00000;
    localparam int        BiosBytes      = 16384;
    localparam busAddrT   BiosWindowBase = 16'h4000;    // Page 1

    // RAM cartridge area, cleared at boot
    localparam ramAddrT   RamCartBase       = 17'h08000;
    localparam int        RamCartBytes      = 32768;
    localparam busAddrT   RamCartWindowBase = 16'h8000;  // Pages 2 and 3

    // Secondary slot register
    localparam busAddrT SubslotRegAddr = 16'hFFFF;
    localparam byteT    UnmappedData   = 8'hFF;         // Open bus value
    localparam int      PageCount      = 4;             // 16 KB pages in 64 KB
    typedef logic [1:0] subslotT;

    // Boot loader sequence
    typedef enum logic [1:0] {
        BootCopyRead,       // Fetch one BIOS byte from flash
        BootCopyWrite,      // Store it into RAM
        BootClear,          // Zero the RAM cartridge area
        BootDone
    } bootStateT;

    // Kind of access in flight
    typedef enum logic [1:0] {
        AccIdle,
        AccRead,
        AccWrite
    } accessT;

endpackage

// ==== ramArbiter.sv ====
module ramArbiter import msxCartPkg::*; (
    input  logic    CLK,
    input  logic    RESET_n,

    // Client 0, boot loader (highest priority)
    input  logic    ReqRd0,
    input  logic    ReqWr0,
    input  ramAddrT ReqAddr0,
    input  byteT    ReqWrData0,
    output logic    Ack0,

    // Client 1, BIOS window
    input  logic    ReqRd1,
    input  logic    ReqWr1,
    input  ramAddrT ReqAddr1,
    input  byteT    ReqWrData1,
    output logic    Ack1,

    // Client 2, RAM cartridge
    input  logic    ReqRd2,
    input  logic    ReqWr2,
    input  ramAddrT ReqAddr2,
    input  byteT    ReqWrData2,
    output logic    Ack2,

    output byteT    AckRdData,      // Valid with any Ack

    // External RAM port
    output ramAddrT RamAddr,
    output byteT    RamWrData,
    output logic    RamRd,
    output logic    RamWr,
    input  byteT    RamRdData,
    input  logic    RamAck
);
    logic [2:0] reqAny;
    logic [2:0] grant;      // One-hot, zero when idle

    assign reqAny = {ReqRd2 || ReqWr2, ReqRd1 || ReqWr1, ReqRd0 || ReqWr0};

    // Grant is taken only when idle and held until the RAM answers
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            grant <= '0;
        end else if (grant == '0) begin
            if (reqAny[0])      grant <= 3'b001;
            else if (reqAny[1]) grant <= 3'b010;
            else if (reqAny[2]) grant <= 3'b100;
        end else if (RamAck) begin
            grant <= '0;
        end
    end

    // Route the granted client out to the RAM
    always_comb begin
        RamRd     = 1'b0;
        RamWr     = 1'b0;
        RamAddr   = ReqAddr0;
        RamWrData = ReqWrData0;
        if (grant[0]) begin
            RamRd = ReqRd0;
            RamWr = ReqWr0;
        end else if (grant[1]) begin
            RamRd     = ReqRd1;
            RamWr     = ReqWr1;
            RamAddr   = ReqAddr1;
            RamWrData = ReqWrData1;
        end else if (grant[2]) begin
            RamRd     = ReqRd2;
            RamWr     = ReqWr2;
            RamAddr   = ReqAddr2;
            RamWrData = ReqWrData2;
        end
    end

    assign Ack0      = grant[0] && RamAck;
    assign Ack1      = grant[1] && RamAck;
    assign Ack2      = grant[2] && RamAck;
    assign AckRdData = RamRdData;

    // A client keeps its request up from grant to acknowledge
    ackNeedsRequest: assert property (@(posedge CLK) disable iff (!RESET_n)
        ({Ack2, Ack1, Ack0} & ~reqAny) == 3'b000);

endmodule

// ==== slotExpander.sv ====
module slotExpander import msxCartPkg::*; (
    input  logic    CLK,
    input  logic    RESET_n,
    input  logic    Ready,          // Boot finished
    input  logic    SltSl_n,
    input  busAddrT Addr,
    input  byteT    BusWrData,
    input  logic    Rd,
    input  logic    Wr,
    output byteT    RdData,
    output logic    BusDone,
    output logic    Wait_n,
    output logic    BiosRd,         // Subslot 0
    output logic    BiosWr,
    input  logic    BiosDone,
    input  byteT    BiosData,
    output logic    RamRd,          // Subslot 1
    output logic    RamWr,
    input  logic    RamDone,
    input  byteT    RamData
);
    logic [2*PageCount-1:0] subslotReg;     // Two bits per page
    logic    open;                          // Cartridge access until BusDone
    logic    accept;
    logic    isReg;
    logic    toCart;
    accessT  hostAcc;
    subslotT pageSub;

    always_comb begin
        if (SltSl_n)  hostAcc = AccIdle;
        else if (Rd)  hostAcc = AccRead;
        else if (Wr)  hostAcc = AccWrite;
        else          hostAcc = AccIdle;
    end

    assign isReg   = Addr == SubslotRegAddr;
    assign pageSub = subslotReg[{Addr[15:14], 1'b0} +: 2];
    assign toCart  = !isReg && (pageSub == 2'd0 || pageSub == 2'd1);
    assign accept  = hostAcc != AccIdle && (!open || BusDone);

    assign BiosRd = accept && toCart && pageSub == 2'd0 && hostAcc == AccRead;
    assign BiosWr = accept && toCart && pageSub == 2'd0 && hostAcc == AccWrite;
    assign RamRd  = accept && toCart && pageSub == 2'd1 && hostAcc == AccRead;
    assign RamWr  = accept && toCart && pageSub == 2'd1 && hostAcc == AccWrite;

    assign Wait_n = Ready && !open;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            subslotReg <= '0;
            open       <= 1'b0;
            BusDone    <= 1'b0;
        end else begin
            // Register and empty subslots answer in one cycle
            BusDone <= BiosDone || RamDone || (accept && !toCart);
            if (accept && isReg && hostAcc == AccWrite)
                subslotReg <= BusWrData;
            if (accept)
                open <= toCart;
            else if (BusDone)
                open <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (BiosDone)     RdData <= BiosData;
        else if (RamDone) RdData <= RamData;
        else if (accept)  RdData <= isReg ? ~subslotReg : UnmappedData;
    end

    // Host waits for BusDone before its next strobe
    noStrobeWhileOpen: assert property (@(posedge CLK) disable iff (!RESET_n)
        open && !BusDone |-> hostAcc == AccIdle);

endmodule

// ==== memCartridge.sv ====
module memCartridge import msxCartPkg::*; #(
    parameter busAddrT WindowBase  = BiosWindowBase,
    parameter int      WindowBytes = BiosBytes,
    parameter ramAddrT RamBase     = BiosRamBase,
    parameter bit      Writable    = 1'b0
) (
    input  logic    CLK,
    input  logic    RESET_n,

    // Strobes from the slot expander
    input  logic    Rd,
    input  logic    Wr,
    input  busAddrT Addr,
    input  byteT    WrData,
    output logic    Done,
    output byteT    Data,

    // RAM client side
    output logic    ReqRd,
    output logic    ReqWr,
    output ramAddrT ReqAddr,
    output byteT    ReqWrData,
    input  logic    Ack,
    input  byteT    ReqRdData
);
    accessT  state;
    busAddrT offset;
    logic    inWindow;
    logic    skipRam;

    // Wraps past the window end when Addr is below the base
    assign offset   = Addr - WindowBase;
    assign inWindow = int'(offset) < WindowBytes;
    assign skipRam  = !inWindow || (Wr && !Writable);   // Read-only window drops writes

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state <= AccIdle;
            Done  <= 1'b0;
        end else begin
            Done <= 1'b0;
            case (state)
                AccIdle: begin
                    if (Rd || Wr) begin
                        if (skipRam)
                            Done <= 1'b1;
                        else
                            state <= Rd ? AccRead : AccWrite;
                    end
                end
                default: begin
                    if (Ack) begin
                        state <= AccIdle;
                        Done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Address and data captured at the strobe
    always_ff @(posedge CLK) begin
        if (state == AccIdle && (Rd || Wr)) begin
            ReqAddr   <= RamBase + ramAddrT'(offset);
            ReqWrData <= WrData;
            Data      <= UnmappedData;
        end else if (state == AccRead && Ack) begin
            Data <= ReqRdData;
        end
    end

    assign ReqRd = state == AccRead;
    assign ReqWr = state == AccWrite;

endmodule

// ==== bootLoader.sv ====
module bootLoader import msxCartPkg::*; (
    input  logic      CLK,
    input  logic      RESET_n,

    // Flash
    output flashAddrT FlashAddr,
    output logic      FlashRd,
    input  byteT      FlashData,
    input  logic      FlashAck,

    // RAM client side
    output logic      ReqRd,
    output logic      ReqWr,
    output ramAddrT   ReqAddr,
    output byteT      ReqWrData,
    input  logic      Ack,

    output logic      Ready         // Releases the rest of the cartridge
);
    bootStateT state;
    logic [$clog2(RamCartBytes)-1:0] count;     // Wide enough for either phase
    byteT      biosByte;
    logic      lastCopy;
    logic      lastClear;

    assign lastCopy  = int'(count) == BiosBytes - 1;
    assign lastClear = int'(count) == RamCartBytes - 1;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state   <= BootCopyRead;
            count   <= '0;
            FlashRd <= 1'b0;
            ReqWr   <= 1'b0;
            Ready   <= 1'b0;
        end else begin
            case (state)
                BootCopyRead: begin
                    if (FlashAck) begin
                        FlashRd <= 1'b0;
                        state   <= BootCopyWrite;
                    end else begin
                        FlashRd <= 1'b1;
                    end
                end
                BootCopyWrite: begin
                    if (Ack) begin
                        ReqWr <= 1'b0;
                        if (lastCopy) begin
                            count <= '0;
                            state <= BootClear;
                        end else begin
                            count <= count + 1'b1;
                            state <= BootCopyRead;
                        end
                    end else begin
                        ReqWr <= 1'b1;
                    end
                end
                BootClear: begin
                    if (Ack) begin
                        ReqWr <= 1'b0;
                        if (lastClear) begin
                            state <= BootDone;
                            Ready <= 1'b1;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end else begin
                        ReqWr <= 1'b1;
                    end
                end
                default: ;      // Stays here until reset
            endcase
        end
    end

    // Flash byte held for the following RAM write
    always_ff @(posedge CLK) begin
        if (state == BootCopyRead && FlashAck)
            biosByte <= FlashData;
    end

    assign FlashAddr = BiosFlashBase + flashAddrT'(count);
    assign ReqRd     = 1'b0;    // Boot only writes
    assign ReqAddr   = (state == BootCopyWrite) ? BiosRamBase + ramAddrT'(count)
                                                : RamCartBase + ramAddrT'(count);
    assign ReqWrData = (state == BootCopyWrite) ? biosByte : 8'h00;

    // Flash is left alone once the cartridge runs
    noFlashAfterBoot: assert property (@(posedge CLK) disable iff (!RESET_n)
        state == BootDone |-> !FlashRd);

endmodule

// ==== cartridgeMain.sv ====
module cartridgeMain import msxCartPkg::*; (
    input  logic      CLK,
    input  logic      RESET_n,

    // Host bus
    input  logic      SltSl_n,
    input  busAddrT   Addr,
    input  byteT      BusWrData,
    input  logic      Rd,
    input  logic      Wr,
    output byteT      RdData,
    output logic      BusDone,
    output logic      Wait_n,

    // Flash
    output flashAddrT FlashAddr,
    output logic      FlashRd,
    input  byteT      FlashData,
    input  logic      FlashAck,

    // External RAM
    output ramAddrT   RamAddr,
    output byteT      RamWrData,
    output logic      RamRd,
    output logic      RamWr,
    input  byteT      RamRdData,
    input  logic      RamAck
);
    logic    sysReset_n;                // Boot loader Ready
    logic    bootRd, bootWr, bootAck;
    ramAddrT bootAddr;
    byteT    bootWrData;
    logic    biosRd, biosWr, biosDone, biosReqRd, biosReqWr, biosAck;
    byteT    biosData, biosReqWrData;
    ramAddrT biosReqAddr;
    logic    cartRd, cartWr, cartDone, cartReqRd, cartReqWr, cartAck;
    byteT    cartData, cartReqWrData;
    ramAddrT cartReqAddr;
    byteT    ramData;                   // Shared client read data

    bootLoader u_boot (
        .CLK, .RESET_n,
        .FlashAddr, .FlashRd, .FlashData, .FlashAck,
        .ReqRd(bootRd), .ReqWr(bootWr), .ReqAddr(bootAddr), .ReqWrData(bootWrData),
        .Ack(bootAck), .Ready(sysReset_n)
    );

    slotExpander u_sltexp (
        .CLK, .RESET_n(sysReset_n), .Ready(sysReset_n),
        .SltSl_n, .Addr, .BusWrData, .Rd, .Wr, .RdData, .BusDone, .Wait_n,
        .BiosRd(biosRd), .BiosWr(biosWr), .BiosDone(biosDone), .BiosData(biosData),
        .RamRd(cartRd), .RamWr(cartWr), .RamDone(cartDone), .RamData(cartData)
    );

    // Read-only copy of the BIOS on page 1
    memCartridge #(
        .WindowBase(BiosWindowBase), .WindowBytes(BiosBytes),
        .RamBase(BiosRamBase), .Writable(1'b0)
    ) u_bios (
        .CLK, .RESET_n(sysReset_n),
        .Rd(biosRd), .Wr(biosWr), .Addr, .WrData(BusWrData),
        .Done(biosDone), .Data(biosData),
        .ReqRd(biosReqRd), .ReqWr(biosReqWr), .ReqAddr(biosReqAddr),
        .ReqWrData(biosReqWrData), .Ack(biosAck), .ReqRdData(ramData)
    );

    memCartridge #(
        .WindowBase(RamCartWindowBase), .WindowBytes(RamCartBytes),
        .RamBase(RamCartBase), .Writable(1'b1)
    ) u_ramcart (
        .CLK, .RESET_n(sysReset_n),
        .Rd(cartRd), .Wr(cartWr), .Addr, .WrData(BusWrData),
        .Done(cartDone), .Data(cartData),
        .ReqRd(cartReqRd), .ReqWr(cartReqWr), .ReqAddr(cartReqAddr),
        .ReqWrData(cartReqWrData), .Ack(cartAck), .ReqRdData(ramData)
    );

    // Runs from the raw reset so boot can use it
    ramArbiter u_arb (
        .CLK, .RESET_n,
        .ReqRd0(bootRd), .ReqWr0(bootWr), .ReqAddr0(bootAddr),
        .ReqWrData0(bootWrData), .Ack0(bootAck),
        .ReqRd1(biosReqRd), .ReqWr1(biosReqWr), .ReqAddr1(biosReqAddr),
        .ReqWrData1(biosReqWrData), .Ack1(biosAck),
        .ReqRd2(cartReqRd), .ReqWr2(cartReqWr), .ReqAddr2(cartReqAddr),
        .ReqWrData2(cartReqWrData), .Ack2(cartAck),
        .AckRdData(ramData),
        .RamAddr, .RamWrData, .RamRd, .RamWr, .RamRdData, .RamAck
    );

endmodule

// ==== memModels_tb.sv ====
module flashModel import msxCartPkg::*; #(
    parameter int Seed = 1
) (
    input  logic      CLK,
    input  logic      RESET_n,
    input  flashAddrT Addr,
    input  logic      Rd,
    output byteT      Data,
    output logic      Ack
);
    integer seed = Seed;
    int     left;               // Cycles still to wait, zero when idle

    always @(posedge CLK or negedge RESET_n) begin : respond
        int delay;
        if (!RESET_n) begin
            Ack  <= 1'b0;
            left <= 0;
        end else begin
            Ack <= 1'b0;
            if (Rd && !Ack) begin
                if (left == 0)
                    delay = 1 + int'($unsigned($random(seed)) % 4);    // New request
                else
                    delay = left;
                if (delay == 1) begin
                    Ack  <= 1'b1;
                    Data <= Addr[7:0] ^ 8'h5A;      // Image content rule
                    left <= 0;
                end else begin
                    left <= delay - 1;
                end
            end
        end
    end

endmodule

module sramModel import msxCartPkg::*; #(
    parameter int Seed = 1
) (
    input  logic    CLK,
    input  logic    RESET_n,
    input  ramAddrT Addr,
    input  byteT    WrData,
    input  logic    Rd,
    input  logic    Wr,
    output byteT    RdData,
    output logic    Ack
);
    integer seed = Seed;
    int     left;
    byteT   mem [0:(2**RamAddrWidth)-1];

    // Non-zero start so a skipped clear shows up
    initial begin
        for (int i = 0; i < 2**RamAddrWidth; i++)
            mem[ramAddrT'(i)] = 8'hA5;
    end

    always @(posedge CLK or negedge RESET_n) begin : respond
        int delay;
        if (!RESET_n) begin
            Ack  <= 1'b0;
            left <= 0;
        end else begin
            Ack <= 1'b0;
            if ((Rd || Wr) && !Ack) begin
                if (left == 0)
                    delay = 1 + int'($unsigned($random(seed)) % 4);
                else
                    delay = left;
                if (delay == 1) begin
                    if (Wr)
                        mem[Addr] = WrData;
                    RdData <= mem[Addr];
                    Ack    <= 1'b1;
                    left   <= 0;
                end else begin
                    left <= delay - 1;
                end
            end
        end
    end

endmodule

// ==== cartridgeMain_tb.sv ====
module cartridgeMain_tb import msxCartPkg::*; ();

    typedef enum bit {OpRead, OpWrite} opT;

    localparam int Seed = 32'h0e10_7605;
    // Every boot byte needs up to 5 handshakes of up to 5 cycles, plus room for the table
    localparam int TimeoutCycles = 5 * (BiosBytes * 2 + RamCartBytes) * 5 + 2000;
    localparam int IgnoreCycles  = 8;      // Watch window for a deselected strobe

    logic      CLK;
    logic      RESET_n;
    logic      SltSl_n;
    busAddrT   Addr;
    byteT      BusWrData;
    logic      Rd;
    logic      Wr;
    byteT      RdData;
    logic      BusDone;
    logic      Wait_n;
    flashAddrT FlashAddr;
    logic      FlashRd;
    byteT      FlashData;
    logic      FlashAck;
    ramAddrT   RamAddr;
    byteT      RamWrData;
    logic      RamRd;
    logic      RamWr;
    byteT      RamRdData;
    logic      RamAck;

    // Stimulus table
    opT      tabOp[$];
    logic    tabSel[$];
    busAddrT tabAddr[$];
    byteT    tabData[$];
    byteT    tabExp[$];

    int checks = 0;
    int errors = 0;
    int cycles = 0;
    bit timedOut = 1'b0;

    cartridgeMain dut0 (.*);

    flashModel #(.Seed(Seed)) flash0 (
        .CLK, .RESET_n, .Addr(FlashAddr), .Rd(FlashRd), .Data(FlashData), .Ack(FlashAck)
    );

    sramModel #(.Seed(Seed)) sram0 (
        .CLK, .RESET_n, .Addr(RamAddr), .WrData(RamWrData), .Rd(RamRd), .Wr(RamWr),
        .RdData(RamRdData), .Ack(RamAck)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Expected BIOS byte for a host address in page 1
    function automatic byteT biosByte(input busAddrT a);
        flashAddrT f;
        f = BiosFlashBase + flashAddrT'(a - BiosWindowBase);
        return f[7:0] ^ 8'h5A;
    endfunction

    task automatic addEntry(input opT op, input logic sel, input busAddrT a,
                            input byteT data, input byteT exp);
        tabOp.push_back(op);
        tabSel.push_back(sel);
        tabAddr.push_back(a);
        tabData.push_back(data);
        tabExp.push_back(exp);
    endtask

    task automatic buildTable();
        addEntry(OpWrite, 1'b0, 16'hFFFF, 8'h44, 8'h00);
        addEntry(OpRead,  1'b0, 16'hFFFF, 8'h00, 8'hBB);     // Register reads back inverted
        addEntry(OpRead,  1'b0, 16'h8000, 8'h00, 8'hFF);     // Page 2 on BIOS, outside its window
        // Page 0 on subslot 2, page 1 BIOS, pages 2 and 3 RAM cartridge
        addEntry(OpWrite, 1'b0, 16'hFFFF, 8'h52, 8'h00);
        addEntry(OpRead,  1'b0, 16'hFFFF, 8'h00, 8'hAD);
        addEntry(OpRead,  1'b0, 16'h4000, 8'h00, biosByte(16'h4000));
        addEntry(OpRead,  1'b0, 16'h4001, 8'h00, biosByte(16'h4001));
        addEntry(OpRead,  1'b0, 16'h5234, 8'h00, biosByte(16'h5234));
        addEntry(OpRead,  1'b0, 16'h7FFF, 8'h00, biosByte(16'h7FFF));
        addEntry(OpRead,  1'b0, 16'h8000, 8'h00, 8'h00);     // Cleared at boot
        addEntry(OpRead,  1'b0, 16'hBFFF, 8'h00, 8'h00);
        addEntry(OpRead,  1'b0, 16'hFFFE, 8'h00, 8'h00);
        addEntry(OpWrite, 1'b0, 16'h8000, 8'h3C, 8'h00);
        addEntry(OpWrite, 1'b0, 16'hBFFF, 8'hC3, 8'h00);
        addEntry(OpWrite, 1'b0, 16'hC123, 8'h5E, 8'h00);
        addEntry(OpRead,  1'b0, 16'h8000, 8'h00, 8'h3C);
        addEntry(OpRead,  1'b0, 16'hBFFF, 8'h00, 8'hC3);
        addEntry(OpRead,  1'b0, 16'hC123, 8'h00, 8'h5E);
        addEntry(OpWrite, 1'b0, 16'h4000, 8'h77, 8'h00);     // BIOS is read-only
        addEntry(OpRead,  1'b0, 16'h4000, 8'h00, biosByte(16'h4000));
        addEntry(OpRead,  1'b0, 16'h0123, 8'h00, 8'hFF);
        addEntry(OpWrite, 1'b1, 16'hFFFF, 8'hFF, 8'h00);     // Slot not selected
        addEntry(OpRead,  1'b0, 16'hFFFF, 8'h00, 8'hAD);
        // Page 0 RAM cartridge, pages 1 and 2 BIOS, page 3 on subslot 3
        addEntry(OpWrite, 1'b0, 16'hFFFF, 8'hC1, 8'h00);
        addEntry(OpRead,  1'b0, 16'hFFFF, 8'h00, 8'h3E);
        addEntry(OpRead,  1'b0, 16'h0100, 8'h00, 8'hFF);
        addEntry(OpRead,  1'b0, 16'hC000, 8'h00, 8'hFF);
        addEntry(OpRead,  1'b0, 16'h5234, 8'h00, biosByte(16'h5234));
    endtask

    // Host is stalled during boot and must see no completions
    task automatic waitBoot();
        int bootCycles;
        bootCycles = 0;
        // Register write tried while boot holds the expander in reset
        SltSl_n   = 1'b0;
        Addr      = SubslotRegAddr;
        BusWrData = 8'hFF;
        Wr        = 1'b1;
        @(negedge CLK);
        Wr      = 1'b0;
        SltSl_n = 1'b1;
        bootCycles++;
        while (Wait_n !== 1'b1) begin
            assert (BusDone === 1'b0) else begin
                errors = errors + 1;
                $display("Error: BusDone = %h during boot, expected %h", BusDone, 1'b0);
            end
            bootCycles++;
            @(negedge CLK);
        end
        checks++;
        $display("Boot finished after %0d cycles", bootCycles);
    endtask

    task automatic runEntry(input int i);
        byteT got;
        int   pulses;
        @(negedge CLK);
        SltSl_n   = tabSel[i];
        Addr      = tabAddr[i];
        BusWrData = tabData[i];
        Rd        = tabOp[i] == OpRead;
        Wr        = tabOp[i] == OpWrite;
        @(negedge CLK);
        Rd = 1'b0;
        Wr = 1'b0;
        if (tabSel[i]) begin
            pulses = 0;
            repeat (IgnoreCycles) begin
                if (BusDone)
                    pulses++;
                @(negedge CLK);
            end
            checks++;
            assert (pulses == 0) else begin
                errors = errors + 1;
                $display("Entry %0d: the cartridge answered a strobe while not selected", i);
            end
        end else begin
            while (BusDone !== 1'b1)
                @(negedge CLK);
            got = RdData;
            if (tabOp[i] == OpRead) begin
                checks++;
                assert (got === tabExp[i]) else begin
                    errors = errors + 1;
                    $display("Error: RdData = %h at Addr %h, expected %h (entry %0d)",
                             got, tabAddr[i], tabExp[i], i);
                end
            end
        end
        SltSl_n = 1'b1;
    endtask

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timedOut)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    initial begin : stimulus
        RESET_n   = 1'b0;
        SltSl_n   = 1'b1;
        Addr      = '0;
        BusWrData = '0;
        Rd        = 1'b0;
        Wr        = 1'b0;
        buildTable();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET_n = 1'b1;
        @(negedge CLK);
        checks++;
        assert (Wait_n === 1'b0) else begin
            errors = errors + 1;
            $display("Error: Wait_n = %h right after reset, expected %h", Wait_n, 1'b0);
        end
        waitBoot();
        for (int i = 0; i < tabOp.size(); i++)
            runEntry(i);
        finishRun();
    end

    always @(posedge CLK) begin : watchdog
        cycles = cycles + 1;
        if (cycles == TimeoutCycles) begin
            timedOut = 1'b1;
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            finishRun();
        end
    end

endmodule

// ==== verilog.f ====
msxCartPkg.sv
ramArbiter.sv
slotExpander.sv
memCartridge.sv
bootLoader.sv
cartridgeMain.sv
memModels_tb.sv
cartridgeMain_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build with Verilator, run, then scan the log for a reported failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module cartridgeMain_tb \
    -f verilog.f -o simv \
    && ./obj_dir/simv | tee sim.log \
    || { echo "Build or simulation did not run"; exit 1; }

grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
